//--- hdl/line_code_consts.svh
`ifndef LINE_CODE_CONSTS_SVH
`define LINE_CODE_CONSTS_SVH

// Byte and symbol widths
`define LC_DATA_W 8
`define LC_SYM_W  10

// Sub-block split, before and after coding
`define LC_5B_W 5
`define LC_3B_W 3
`define LC_6B_W 6
`define LC_4B_W 4

// Control families, EDCBA values
`define LC_K28 5'd28
`define LC_K23 5'd23
`define LC_K27 5'd27
`define LC_K29 5'd29
`define LC_K30 5'd30

`endif

//--- hdl/line_code_pkg.sv
`include "line_code_consts.svh"

package line_code_pkg;

        // Byte entering the encoder
        typedef struct packed {
                logic [`LC_DATA_W-1:0] data;
                logic                  is_k;
        } byte_word_t;

        // Symbol is abcdei then fghj, a at the MSB and sent first
        typedef struct packed {
                logic [`LC_SYM_W-1:0] symbol;
                logic                 code_err;
        } code_word_t;

        typedef enum logic {
                RD_NEG = 1'b0,
                RD_POS = 1'b1
        } rd_t;

        typedef logic [`LC_6B_W-1:0] sub6_t;
        typedef logic [`LC_4B_W-1:0] sub4_t;

endpackage

//--- hdl/enc_5b6b.sv
`include "line_code_consts.svh"

module enc_5b6b (
        input  logic [`LC_5B_W-1:0]  din,
        output line_code_pkg::sub6_t code,
        output logic                 neutral,
        output logic                 flip_neutral
);

        // 6b codes in RD_NEG form, abcdei
        always_comb begin
                case (din)
                        5'd0:  code = 6'b100111;
                        5'd1:  code = 6'b011101;
                        5'd2:  code = 6'b101101;
                        5'd3:  code = 6'b110001;
                        5'd4:  code = 6'b110101;
                        5'd5:  code = 6'b101001;
                        5'd6:  code = 6'b011001;
                        5'd7:  code = 6'b111000;
                        5'd8:  code = 6'b111001;
                        5'd9:  code = 6'b100101;
                        5'd10: code = 6'b010101;
                        5'd11: code = 6'b110100;
                        5'd12: code = 6'b001101;
                        5'd13: code = 6'b101100;
                        5'd14: code = 6'b011100;
                        5'd15: code = 6'b010111;
                        5'd16: code = 6'b011011;
                        5'd17: code = 6'b100011;
                        5'd18: code = 6'b010011;
                        5'd19: code = 6'b110010;
                        5'd20: code = 6'b001011;
                        5'd21: code = 6'b101010;
                        5'd22: code = 6'b011010;
                        5'd23: code = 6'b111010;
                        5'd24: code = 6'b110011;
                        5'd25: code = 6'b100110;
                        5'd26: code = 6'b010110;
                        5'd27: code = 6'b110110;
                        5'd28: code = 6'b001110;
                        5'd29: code = 6'b101110;
                        5'd30: code = 6'b011110;
                        5'd31: code = 6'b101011;
                endcase
        end

        assign neutral = ($countones(code) == 3);

        // D7 is balanced but still has two forms
        assign flip_neutral = (din == 5'd7);

endmodule

//--- hdl/enc_3b4b.sv
`include "line_code_consts.svh"

module enc_3b4b (
        input  logic [`LC_3B_W-1:0]  din,
        input  line_code_pkg::rd_t   rd_mid,
        input  logic                 use_alt,
        input  logic                 force_flip,
        output line_code_pkg::sub4_t code
);

        line_code_pkg::sub4_t base;
        logic                 flip;

        // fghj in RD_NEG form
        always_comb begin
                case (din)
                        3'd0:    base = 4'b1011;
                        3'd1:    base = 4'b1001;
                        3'd2:    base = 4'b0101;
                        3'd3:    base = 4'b1100;
                        3'd4:    base = 4'b1101;
                        3'd5:    base = 4'b1010;
                        3'd6:    base = 4'b0110;
                        default: base = use_alt ? 4'b0111 : 4'b1110;
                endcase
        end

        // Unbalanced codes and x.3 follow the disparity after the 6b block.
        // Under K28 the other balanced codes invert at RD_NEG instead.
        always_comb begin
                case (din)
                        3'd0, 3'd3, 3'd4, 3'd7: begin
                                flip = (rd_mid == line_code_pkg::RD_POS);
                        end
                        default: begin
                                flip = force_flip && (rd_mid == line_code_pkg::RD_NEG);
                        end
                endcase
        end

        assign code = flip ? ~base : base;

endmodule

//--- hdl/pipe_reg.sv
module pipe_reg #(
        parameter type payload_t = logic
) (
        input  logic     pclk,
        input  logic     rst_n,
        input  logic     in_valid,
        output logic     in_ready,
        input  payload_t in_payload,
        output logic     out_valid,
        input  logic     out_ready,
        output payload_t out_payload
);

        // Free slot, or the held item leaves this cycle
        assign in_ready = !out_valid || out_ready;

        always_ff @(posedge pclk) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                end else if (in_ready) begin
                        out_valid <= in_valid;
                end
        end

        always_ff @(posedge pclk) begin
                if (in_valid && in_ready) begin
                        out_payload <= in_payload;
                end
        end

        //////////////////////////////
        // Checks
        //////////////////////////////

        // Stalled item stays put until taken
        assert property (@(posedge pclk) disable iff (!rst_n)
                (out_valid && !out_ready) |=> (out_valid && $stable(out_payload)));

endmodule

//--- hdl/symbol_encoder.sv
`include "line_code_consts.svh"

module symbol_encoder (
        input  logic                      pclk,
        input  logic                      rst_n,
        input  logic                      in_valid,
        output logic                      in_ready,
        input  line_code_pkg::byte_word_t in_byte,
        output logic                      out_valid,
        input  logic                      out_ready,
        output line_code_pkg::code_word_t out_code
);

        logic [`LC_5B_W-1:0]  low5;
        logic [`LC_3B_W-1:0]  high3;
        line_code_pkg::rd_t   rd;
        line_code_pkg::rd_t   rd_mid;
        line_code_pkg::rd_t   rd_next;
        line_code_pkg::sub6_t tbl6;
        line_code_pkg::sub6_t code6;
        line_code_pkg::sub4_t code4;
        logic                 neutral6;
        logic                 flip6;
        logic                 k28;
        logic                 k_alt7;
        logic                 k_legal;
        logic                 use_alt;
        logic [`LC_SYM_W-1:0] symbol;
        logic [3:0]           sym_ones;

        assign in_ready  = out_ready;
        assign out_valid = in_valid;

        assign low5  = in_byte.data[`LC_5B_W-1:0];
        assign high3 = in_byte.data[`LC_DATA_W-1:`LC_5B_W];

        //////////////////////////////
        // Control symbol decode
        //////////////////////////////

        assign k28    = in_byte.is_k && (low5 == `LC_K28);
        assign k_alt7 = in_byte.is_k && (high3 == 3'd7) &&
                        (low5 == `LC_K23 || low5 == `LC_K27 ||
                         low5 == `LC_K29 || low5 == `LC_K30);
        assign k_legal = k28 || k_alt7;

        //////////////////////////////
        // 6b sub-block
        //////////////////////////////

        enc_5b6b u_enc_5b6b (
                .din          (low5),
                .code         (tbl6),
                .neutral      (neutral6),
                .flip_neutral (flip6)
        );

        always_comb begin
                if (k28) begin
                        code6 = (rd == line_code_pkg::RD_NEG) ? 6'b001111 : 6'b110000;
                end else if (rd == line_code_pkg::RD_POS && (!neutral6 || flip6)) begin
                        code6 = ~tbl6;
                end else begin
                        code6 = tbl6;
                end
        end

        // Unbalanced 6b code swaps the disparity
        always_comb begin
                if (k28 || !neutral6) begin
                        rd_mid = (rd == line_code_pkg::RD_NEG) ? line_code_pkg::RD_POS
                                                                : line_code_pkg::RD_NEG;
                end else begin
                        rd_mid = rd;
                end
        end

        //////////////////////////////
        // 4b sub-block
        //////////////////////////////

        // A7 avoids a run of five across the e i f g h boundary
        assign use_alt = k_legal ||
                         (rd_mid == line_code_pkg::RD_NEG &&
                          (low5 == 5'd17 || low5 == 5'd18 || low5 == 5'd20)) ||
                         (rd_mid == line_code_pkg::RD_POS &&
                          (low5 == 5'd11 || low5 == 5'd13 || low5 == 5'd14));

        enc_3b4b u_enc_3b4b (
                .din        (high3),
                .rd_mid     (rd_mid),
                .use_alt    (use_alt),
                .force_flip (k28),
                .code       (code4)
        );

        assign symbol            = {code6, code4};
        assign out_code.symbol   = symbol;
        assign out_code.code_err = in_byte.is_k && !k_legal;

        // Running disparity
        assign sym_ones = 4'($countones(symbol));

        always_comb begin
                if (sym_ones > 4'd5) begin
                        rd_next = line_code_pkg::RD_POS;
                end else if (sym_ones < 4'd5) begin
                        rd_next = line_code_pkg::RD_NEG;
                end else begin
                        rd_next = rd;
                end
        end

        always_ff @(posedge pclk) begin
                if (!rst_n) begin
                        rd <= line_code_pkg::RD_NEG;
                end else if (in_valid && out_ready) begin
                        rd <= rd_next;
                end
        end

        // Symbol weight is 4, 5 or 6 and always pulls back toward zero
        assert property (@(posedge pclk) disable iff (!rst_n)
                (out_valid && out_ready) |->
                        (sym_ones == 4'd5) ||
                        (sym_ones == 4'd6 && rd == line_code_pkg::RD_NEG) ||
                        (sym_ones == 4'd4 && rd == line_code_pkg::RD_POS));

endmodule

//--- hdl/line_coder_top.sv
`include "line_code_consts.svh"

module line_coder_top (
        input  logic                  pclk,
        input  logic                  rst_n,
        input  logic                  in_valid,
        output logic                  in_ready,
        input  logic [`LC_DATA_W-1:0] in_data,
        input  logic                  in_is_k,
        output logic                  out_valid,
        input  logic                  out_ready,
        output logic [`LC_SYM_W-1:0]  out_symbol,
        output logic                  out_code_err
);

        line_code_pkg::byte_word_t in_word;
        line_code_pkg::byte_word_t enc_byte;
        line_code_pkg::code_word_t enc_code;
        line_code_pkg::code_word_t out_word;
        logic                      enc_in_valid;
        logic                      enc_in_ready;
        logic                      enc_out_valid;
        logic                      enc_out_ready;

        assign in_word.data = in_data;
        assign in_word.is_k = in_is_k;

        pipe_reg #(
                .payload_t (line_code_pkg::byte_word_t)
        ) u_in_slice (
                .pclk        (pclk),
                .rst_n       (rst_n),
                .in_valid    (in_valid),
                .in_ready    (in_ready),
                .in_payload  (in_word),
                .out_valid   (enc_in_valid),
                .out_ready   (enc_in_ready),
                .out_payload (enc_byte)
        );

        symbol_encoder u_encoder (
                .pclk      (pclk),
                .rst_n     (rst_n),
                .in_valid  (enc_in_valid),
                .in_ready  (enc_in_ready),
                .in_byte   (enc_byte),
                .out_valid (enc_out_valid),
                .out_ready (enc_out_ready),
                .out_code  (enc_code)
        );

        pipe_reg #(
                .payload_t (line_code_pkg::code_word_t)
        ) u_out_slice (
                .pclk        (pclk),
                .rst_n       (rst_n),
                .in_valid    (enc_out_valid),
                .in_ready    (enc_out_ready),
                .in_payload  (enc_code),
                .out_valid   (out_valid),
                .out_ready   (out_ready),
                .out_payload (out_word)
        );

        assign out_symbol   = out_word.symbol;
        assign out_code_err = out_word.code_err;

endmodule

//--- bench/line_coder_model.svh
`ifndef LINE_CODER_MODEL_SVH
`define LINE_CODER_MODEL_SVH

// 5b/6b codes at negative disparity, indexed by EDCBA
localparam logic [5:0] six_neg [0:31] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b codes at negative disparity, data and control columns
localparam logic [3:0] four_data [0:7] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};
localparam logic [3:0] four_ctrl [0:7] = '{
        4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111
};

// K28.y, K23.7, K27.7, K29.7, K30.7
function automatic logic legal_control(input logic [7:0] data);
        logic [4:0] x;
        x = data[4:0];
        return x == 5'd28 ||
               (data[7:5] == 3'd7 && (x == 5'd23 || x == 5'd27 || x == 5'd29 || x == 5'd30));
endfunction

// Returns {symbol, code_err}, rd is 1 for positive disparity
function automatic logic [10:0] encode_byte(input logic [7:0] data, input logic is_k,
                                            input logic rd_in, output logic rd_out);
        logic [4:0] x;
        logic [2:0] y;
        logic       k;
        logic       rd;
        logic [5:0] c6;
        logic [3:0] c4;
        x  = data[4:0];
        y  = data[7:5];
        k  = is_k && legal_control(data);
        rd = rd_in;
        c6 = (k && x == 5'd28) ? 6'b001111 : six_neg[x];
        if (rd && ($countones(c6) != 3 || x == 5'd7)) begin
                c6 = ~c6;
        end
        if ($countones(c6) != 3) begin
                rd = ($countones(c6) > 3);
        end
        if (k) begin
                c4 = four_ctrl[y];
        end else if (y == 3'd7 && ((!rd && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                                   (rd && (x == 5'd11 || x == 5'd13 || x == 5'd14)))) begin
                c4 = 4'b0111;
        end else begin
                c4 = four_data[y];
        end
        // Control and x.3 codes invert at positive disparity though balanced
        if (rd && (k || y == 3'd3 || $countones(c4) != 2)) begin
                c4 = ~c4;
        end
        if ($countones(c4) != 2) begin
                rd = ($countones(c4) > 2);
        end
        rd_out = rd;
        return {c6, c4, is_k && !k};
endfunction

`endif

//--- bench/tb_line_coder.sv
`include "line_code_consts.svh"

module tb_line_coder;

        localparam int clk_period      = 40;
        localparam int reset_cycles    = 16;
        localparam int total_bytes     = 1 + 256 + 48 + 1 + 200;
        localparam int watchdog_cycles = reset_cycles + total_bytes * 4 + 300;
        localparam logic [7:0] k_codes [0:11] = '{
                8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC,
                8'hDC, 8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE
        };

        logic                  pclk;
        logic                  rst_n;
        logic                  in_valid;
        logic                  in_ready;
        logic [`LC_DATA_W-1:0] in_data;
        logic                  in_is_k;
        logic                  out_valid;
        logic                  out_ready;
        logic [`LC_SYM_W-1:0]  out_symbol;
        logic                  out_code_err;

        integer      seed = 4;
        integer      errors = 0;
        integer      checks = 0;
        integer      out_errors = 0;
        integer      out_checks = 0;
        integer      cycle = 0;
        integer      balance = -1;
        integer      last_out_cyc = -1;
        logic        model_rd = 1'b0;
        logic        stall_mode = 1'b0;
        logic        check_latency = 1'b0;
        logic        held_valid = 1'b0;
        logic [10:0] held_word;
        logic        ready_pattern [0:1023];
        logic [10:0] exp_q[$];
        integer      in_cyc_q[$];

        `include "line_coder_model.svh"

        line_coder_top uut (
                .pclk         (pclk),
                .rst_n        (rst_n),
                .in_valid     (in_valid),
                .in_ready     (in_ready),
                .in_data      (in_data),
                .in_is_k      (in_is_k),
                .out_valid    (out_valid),
                .out_ready    (out_ready),
                .out_symbol   (out_symbol),
                .out_code_err (out_code_err)
        );

        initial begin
                pclk = 1'b0;
                forever #(clk_period / 2) pclk = ~pclk;
        end

        always @(posedge pclk) begin
                cycle <= cycle + 1;
        end

        // Sink side back-pressure
        initial begin
                out_ready = 1'b1;
                forever begin
                        @(posedge pclk);
                        #2;
                        out_ready = stall_mode ? ready_pattern[cycle % 1024] : 1'b1;
                end
        end

        initial begin
                #(watchdog_cycles * clk_period);
                $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
                $display("Checks failed");
                $finish;
        end

        //////////////////////////////
        // Output monitor
        //////////////////////////////

        task automatic check_output();
                logic [10:0] expected;
                integer      in_cyc;
                if (exp_q.size() == 0) begin
                        $display("Symbol %b came out at %0t with nothing sent", out_symbol, $time);
                        out_errors++;
                end else begin
                        expected = exp_q.pop_front();
                        in_cyc = in_cyc_q.pop_front();
                        out_checks++;
                        if ({out_symbol, out_code_err} != expected) begin
                                $display("[FAIL] %0t: got %b err %b, expected %b err %b", $time,
                                         out_symbol, out_code_err, expected[10:1], expected[0]);
                                out_errors++;
                        end
                        if (check_latency && cycle - in_cyc != 2) begin
                                $display("[FAIL] %0t: latency %0d cycles, expected 2", $time,
                                         cycle - in_cyc);
                                out_errors++;
                        end
                        if (check_latency && last_out_cyc >= 0 &&
                            cycle - last_out_cyc != 1) begin
                                $display("[FAIL] %0t: %0d cycles between symbols, expected 1",
                                         $time, cycle - last_out_cyc);
                                out_errors++;
                        end
                        last_out_cyc = check_latency ? cycle : -1;
                        balance = balance + 2 * $countones(out_symbol) - 10;
                        if (balance < -1 || balance > 1) begin
                                $display("[FAIL] %0t: running disparity sum %0d", $time, balance);
                                out_errors++;
                        end
                end
        endtask

        // Sampled mid-cycle where every DUT output has settled
        always @(negedge pclk) begin
                if (rst_n) begin
                        if (held_valid &&
                            (!out_valid || {out_symbol, out_code_err} != held_word)) begin
                                $display("[FAIL] %0t: output changed while stalled", $time);
                                out_errors++;
                        end
                        held_valid = out_valid && !out_ready;
                        held_word = {out_symbol, out_code_err};
                        if (out_valid && out_ready) begin
                                check_output();
                        end
                end
        end

        //////////////////////////////
        // Driver helpers
        //////////////////////////////

        task automatic send_byte(input logic [7:0] data, input logic is_k);
                logic        rd_after;
                logic [10:0] expected;
                in_valid = 1'b1;
                in_data = data;
                in_is_k = is_k;
                @(negedge pclk);
                while (!in_ready) begin
                        @(negedge pclk);
                end
                expected = encode_byte(data, is_k, model_rd, rd_after);
                model_rd = rd_after;
                exp_q.push_back(expected);
                in_cyc_q.push_back(cycle);
                @(posedge pclk);
                #2;
        endtask

        task automatic wait_drain();
                integer waited;
                waited = 0;
                while (exp_q.size() != 0 && waited < 100) begin
                        @(posedge pclk);
                        #2;
                        waited++;
                end
                if (exp_q.size() != 0) begin
                        $display("Output did not drain, %0d symbols missing", exp_q.size());
                        errors++;
                end
        endtask

        task automatic expect_next_output(input logic [9:0] symbol, input logic code_err);
                integer waited;
                waited = 0;
                @(negedge pclk);
                while (!(out_valid && out_ready) && waited < 20) begin
                        @(negedge pclk);
                        waited++;
                end
                checks++;
                if (!(out_valid && out_ready)) begin
                        $display("No symbol came out within 20 cycles");
                        errors++;
                end else if (out_symbol != symbol || out_code_err != code_err) begin
                        $display("[FAIL] %0t: got %b err %b, expected %b err %b", $time,
                                 out_symbol, out_code_err, symbol, code_err);
                        errors++;
                end
                @(posedge pclk);
                #2;
        endtask

        //////////////////////////////
        // Tests
        //////////////////////////////

        task automatic probe_reset_state();
                @(negedge pclk);
                checks++;
                if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
                        $display("[FAIL] %0t: after reset out_valid %b in_ready %b", $time,
                                 out_valid, in_ready);
                        errors++;
                end
                @(posedge pclk);
                #2;
                send_byte(8'h00, 1'b0);
                in_valid = 1'b0;
                expect_next_output(10'b1001110100, 1'b0);
                wait_drain();
        endtask

        task automatic sweep_data_bytes();
                check_latency = 1'b1;
                for (int i = 0; i < 256; i++) begin
                        send_byte(8'(i), 1'b0);
                end
                in_valid = 1'b0;
                wait_drain();
                check_latency = 1'b0;
        endtask

        task automatic cover_control_symbols();
                logic target;
                for (int t = 0; t < 2; t++) begin
                        for (int i = 0; i < 12; i++) begin
                                target = t[0];
                                // D0.1 flips the disparity, D3.1 keeps it
                                if (model_rd != target) begin
                                        send_byte(8'h20, 1'b0);
                                end else begin
                                        send_byte(8'h23, 1'b0);
                                end
                                if (k_codes[i] == 8'hBC && !target) begin
                                        in_valid = 1'b0;
                                        wait_drain();
                                        send_byte(k_codes[i], 1'b1);
                                        in_valid = 1'b0;
                                        expect_next_output(10'b0011111010, 1'b0);
                                end else begin
                                        send_byte(k_codes[i], 1'b1);
                                end
                        end
                end
                in_valid = 1'b0;
                wait_drain();
        endtask

        task automatic reject_illegal_control();
                logic        rd_after;
                logic [10:0] data_word;
                data_word = encode_byte(8'h00, 1'b0, model_rd, rd_after);
                send_byte(8'h00, 1'b1);
                in_valid = 1'b0;
                expect_next_output(data_word[10:1], 1'b1);
                wait_drain();
        endtask

        task automatic stream_random_stalls();
                for (int i = 0; i < 1024; i++) begin
                        ready_pattern[i] = ($random(seed) & 1) == 1;
                end
                @(negedge pclk);
                stall_mode = 1'b1;
                @(posedge pclk);
                #2;
                for (int i = 0; i < 200; i++) begin
                        send_byte(8'($random(seed)), 1'b0);
                end
                in_valid = 1'b0;
                @(negedge pclk);
                stall_mode = 1'b0;
                @(posedge pclk);
                #2;
                wait_drain();
        endtask

        initial begin
                rst_n = 1'b0;
                in_valid = 1'b0;
                in_data = '0;
                in_is_k = 1'b0;
                repeat (reset_cycles) @(posedge pclk);
                #2;
                rst_n = 1'b1;
                probe_reset_state();
                sweep_data_bytes();
                cover_control_symbols();
                reject_illegal_control();
                stream_random_stalls();
                $display("Checks: %0d, errors: %0d", checks + out_checks, errors + out_errors);
                if (errors + out_errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

//--- build.f
+incdir+hdl
+incdir+bench
hdl/line_code_pkg.sv
hdl/enc_5b6b.sv
hdl/enc_3b4b.sv
hdl/pipe_reg.sv
hdl/symbol_encoder.sv
hdl/line_coder_top.sv
bench/tb_line_coder.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_line_coder
RTL_TOP   := line_coder_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv bench/*.svh)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
